/* sim.f */
rv32_csr_pkg.sv
rv32_trap_pkg.sv
priv_internal_if.sv
csr_rfile.sv
trap_ctrl.sv
priv_unit.sv
priv_unit_tb.sv

/* priv_unit_tb.sv */
// ------------------------------------------------------------
// Table-driven testbench for the machine privilege unit. Steps
// get expected values from a CSR model, then a loop applies them
// ------------------------------------------------------------
module priv_unit_tb
  import rv32_csr_pkg::*;
  import rv32_trap_pkg::*;
();

  localparam int TIMEOUT     = 50;
  localparam int IDLE_CYCLES = 20;

  typedef struct packed {
    logic       csr_valid;
    csr_op_t    op;
    csr_addr_t  addr;
    word_t      wdata;
    logic       exc_valid;
    exc_cause_t cause;
    word_t      pc;
    word_t      tval;
    logic       mret;
    logic       irq;
    word_t      exp_rdata;
    logic       exp_illegal;
    logic       exp_trap;
    word_t      exp_pc;
  } step_t;

  logic       CLK;
  logic       nRST;
  logic       csr_valid;
  logic       csr_ready;
  csr_op_t    csr_op;
  csr_addr_t  csr_addr;
  word_t      csr_wdata;
  word_t      csr_rdata;
  logic       csr_illegal;
  logic       instr_retired;
  logic       exc_valid;
  exc_cause_t exc_cause;
  word_t      exc_pc;
  word_t      exc_tval;
  logic       mret;
  logic       ext_irq;
  logic       trap_taken;
  word_t      redirect_pc;

  // Reference CSR state
  word_t m_mtvec, m_mepc, m_mcause, m_mtval, m_mie, m_mtimecmp, m_mscratch;
  logic  m_mie_bit;
  logic  m_mpie;
  logic  irq_level;
  step_t steps[$];
  int    seed = 79;

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  priv_unit #(.HART_ID(32'd5)) dut_i (.*);

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  // Model read, limited to the registers the table touches
  function automatic word_t model_read(input csr_addr_t addr, output logic known);
    known = 1'b1;
    case (addr)
      MSTATUS_ADDR:  return {24'd0, m_mpie, 3'd0, m_mie_bit, 3'd0};
      MISA_ADDR:     return 32'h4000_0100;
      MHARTID_ADDR:  return 32'd5;
      MIE_ADDR:      return m_mie;
      MTVEC_ADDR:    return m_mtvec;
      MSCRATCH_ADDR: return m_mscratch;
      MEPC_ADDR:     return m_mepc;
      MCAUSE_ADDR:   return m_mcause;
      MTVAL_ADDR:    return m_mtval;
      MTIMECMP_ADDR: return m_mtimecmp;
      default: begin
        known = 1'b0;
        return 32'd0;
      end
    endcase
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  // Hold the request until it is accepted, pulses last one cycle
  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!csr_ready) begin
      assert (cycles < TIMEOUT) else begin
        $display("timeout at %0t: csr_ready stayed low", $time);
        $display("TESTBENCH FAILED");
        $fatal(1);
      end
      @(negedge CLK);
      exc_valid = 1'b0;
      mret      = 1'b0;
      #1;
      cycles++;
    end
  endtask

  // Append one step, expected response taken from the model
  task automatic add_step(input logic valid, input csr_op_t op, input csr_addr_t addr,
                          input word_t wdata, input logic exc, input exc_cause_t cause,
                          input word_t pc, input logic ret);
    step_t s;
    word_t pend;
    word_t old;
    word_t new_val;
    logic  known;
    logic  take_irq;
    int    code;
    s           = '0;
    s.csr_valid = valid;
    s.op        = op;
    s.addr      = addr;
    s.wdata     = wdata;
    s.exc_valid = exc;
    s.cause     = cause;
    s.pc        = pc;
    s.tval      = ~pc;
    s.mret      = ret;
    s.irq       = irq_level;
    // mtime stays between 16 and 2^32 while the table runs
    pend     = {20'd0, irq_level, 3'd0, (m_mtimecmp < 32'd16), 3'd0, 1'b0, 3'd0} & m_mie;
    take_irq = m_mie_bit && (pend != 0) && !exc && !ret;
    code     = pend[11] ? 11 : (pend[3] ? 3 : 7);
    s.exp_trap = exc || take_irq;
    s.exp_pc   = {m_mtvec[31:2], 2'b00};
    if (ret && !exc) begin
      s.exp_pc = m_mepc;
    end else if (take_irq && m_mtvec[1:0] == 2'b01) begin
      s.exp_pc = s.exp_pc + 4 * code;
    end
    if (s.exp_trap) begin
      m_mepc    = pc;
      m_mcause  = exc ? {28'd0, cause} : (32'h8000_0000 | code);
      m_mtval   = exc ? ~pc : 32'd0;
      m_mpie    = m_mie_bit;
      m_mie_bit = 1'b0;
    end else if (ret) begin
      m_mie_bit = m_mpie;
      m_mpie    = 1'b1;
    end
    // A held request completes after the trap update
    if (valid) begin
      old           = model_read(addr, known);
      s.exp_rdata   = old;
      s.exp_illegal = !known || ((addr == MISA_ADDR || addr == MHARTID_ADDR) &&
                                 (op == CSR_RW || wdata != 32'd0));
      case (op)
        CSR_RW:  new_val = wdata;
        CSR_RS:  new_val = old | wdata;
        default: new_val = old & ~wdata;
      endcase
      if (!s.exp_illegal) begin
        case (addr)
          MSTATUS_ADDR: begin
            m_mie_bit = new_val[3];
            m_mpie    = new_val[7];
          end
          MIE_ADDR:      m_mie      = new_val & 32'h0000_0888;
          MTVEC_ADDR:    m_mtvec    = new_val;
          MSCRATCH_ADDR: m_mscratch = new_val;
          MEPC_ADDR:     m_mepc     = new_val;
          MCAUSE_ADDR:   m_mcause   = new_val;
          MTVAL_ADDR:    m_mtval    = new_val;
          MTIMECMP_ADDR: m_mtimecmp = new_val;
          default: ;
        endcase
      end
    end
    steps.push_back(s);
  endtask

  task automatic csr_access(input csr_op_t op, input csr_addr_t addr, input word_t wdata);
    add_step(1'b1, op, addr, wdata, 1'b0, EXC_ECALL_M, 32'd0, 1'b0);
  endtask

  // Cycle with no CSR request, optionally an exception or mret
  task automatic pulse_step(input logic exc, input exc_cause_t cause, input word_t pc,
                            input logic ret);
    add_step(1'b0, CSR_RS, 12'h000, 32'd0, exc, cause, pc, ret);
  endtask

  task automatic build_table();
    m_mtvec    = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_mtval    = '0;
    m_mie      = '0;
    m_mtimecmp = '0;
    m_mscratch = '0;
    m_mie_bit  = 1'b0;
    m_mpie     = 1'b0;
    irq_level  = 1'b0;
    // Swap, set and clear with random data
    csr_access(CSR_RW, MSCRATCH_ADDR, rand_word());
    csr_access(CSR_RS, MSCRATCH_ADDR, rand_word());
    csr_access(CSR_RC, MSCRATCH_ADDR, rand_word());
    csr_access(CSR_RW, MTVEC_ADDR, rand_word());
    csr_access(CSR_RS, MTVEC_ADDR, rand_word());
    csr_access(CSR_RC, MTVEC_ADDR, rand_word());
    csr_access(CSR_RS, MISA_ADDR, 32'd0);
    csr_access(CSR_RS, MHARTID_ADDR, 32'd0);
    // Unmapped address, then a write to a read-only register
    csr_access(CSR_RW, 12'h7C0, rand_word());
    csr_access(CSR_RW, MHARTID_ADDR, rand_word());
    csr_access(CSR_RS, MSCRATCH_ADDR, 32'd0);
    // ecall in direct mode and the return
    csr_access(CSR_RW, MTVEC_ADDR, 32'h0000_1000);
    csr_access(CSR_RS, MSTATUS_ADDR, 32'h8);
    pulse_step(1'b1, EXC_ECALL_M, 32'h0000_0440, 1'b0);
    csr_access(CSR_RS, MEPC_ADDR, 32'd0);
    csr_access(CSR_RS, MCAUSE_ADDR, 32'd0);
    csr_access(CSR_RS, MTVAL_ADDR, 32'd0);
    csr_access(CSR_RS, MSTATUS_ADDR, 32'd0);
    pulse_step(1'b0, EXC_ECALL_M, 32'd0, 1'b1);
    csr_access(CSR_RS, MSTATUS_ADDR, 32'd0);
    // External interrupt, vectored
    csr_access(CSR_RW, MTVEC_ADDR, 32'h0000_2001);
    csr_access(CSR_RW, MIE_ADDR, 32'h800);
    irq_level = 1'b1;
    pulse_step(1'b0, EXC_ECALL_M, 32'h0000_0600, 1'b0);
    csr_access(CSR_RS, MCAUSE_ADDR, 32'd0);
    irq_level = 1'b0;
    pulse_step(1'b0, EXC_ECALL_M, 32'd0, 1'b1);
    // Masked by mstatus, then by mie
    csr_access(CSR_RC, MSTATUS_ADDR, 32'h8);
    irq_level = 1'b1;
    pulse_step(1'b0, EXC_ECALL_M, 32'h0000_0610, 1'b0);
    csr_access(CSR_RC, MIE_ADDR, 32'h800);
    csr_access(CSR_RS, MSTATUS_ADDR, 32'h8);
    pulse_step(1'b0, EXC_ECALL_M, 32'h0000_0620, 1'b0);
    irq_level = 1'b0;
    // Timer compare moved below mtime
    csr_access(CSR_RW, MTIMECMP_ADDR, 32'hFFFF_FFFF);
    csr_access(CSR_RS, MIE_ADDR, 32'h80);
    pulse_step(1'b0, EXC_ECALL_M, 32'h0000_0700, 1'b0);
    csr_access(CSR_RW, MTIMECMP_ADDR, 32'd2);
    pulse_step(1'b0, EXC_ECALL_M, 32'h0000_0710, 1'b0);
    csr_access(CSR_RS, MCAUSE_ADDR, 32'd0);
    csr_access(CSR_RW, MIE_ADDR, 32'd0);
    pulse_step(1'b0, EXC_ECALL_M, 32'd0, 1'b1);
    // CSR request held by an exception in the same cycle
    add_step(1'b1, CSR_RS, MSTATUS_ADDR, 32'd0, 1'b1, EXC_ILLEGAL_INSTR, 32'h0000_0880, 1'b0);
    csr_access(CSR_RS, MSTATUS_ADDR, 32'd0);
    csr_access(CSR_RW, MSTATUS_ADDR, 32'd0);
  endtask

  task automatic apply_step(input step_t s);
    logic stall;
    @(negedge CLK);
    csr_valid     = s.csr_valid;
    csr_op        = s.op;
    csr_addr      = s.addr;
    csr_wdata     = s.wdata;
    exc_valid     = s.exc_valid;
    exc_cause     = s.cause;
    exc_pc        = s.pc;
    exc_tval      = s.tval;
    mret          = s.mret;
    ext_irq       = s.irq;
    instr_retired = 1'b0;
    #1;
    stall = s.exp_trap || (s.mret && !s.exc_valid);
    check_value("trap_taken", trap_taken, s.exp_trap);
    check_value("csr_ready", csr_ready, !stall);
    if (stall) begin
      check_value("redirect_pc", redirect_pc, s.exp_pc);
    end
    if (s.csr_valid) begin
      wait_ready();
      check_value("csr_rdata", csr_rdata, s.exp_rdata);
      check_value("csr_illegal", csr_illegal, s.exp_illegal);
    end
  endtask

  task automatic read_csr(input csr_addr_t addr, output word_t data);
    @(negedge CLK);
    csr_valid     = 1'b1;
    csr_op        = CSR_RS;
    csr_addr      = addr;
    csr_wdata     = 32'd0;
    instr_retired = 1'b0;
    #1;
    wait_ready();
    data = csr_rdata;
  endtask

  // mcycle reads IDLE_CYCLES + 1 cycles apart, minstret around them
  task automatic check_counters();
    word_t cyc0, cyc1, ret0, ret1, rnd;
    int    retired;
    retired = 0;
    read_csr(MINSTRET_ADDR, ret0);
    read_csr(MCYCLE_ADDR, cyc0);
    repeat (IDLE_CYCLES) begin
      @(negedge CLK);
      csr_valid     = 1'b0;
      rnd           = $random(seed);
      instr_retired = rnd[0];
      retired       = retired + rnd[0];
    end
    read_csr(MCYCLE_ADDR, cyc1);
    read_csr(MINSTRET_ADDR, ret1);
    check_value("mcycle delta", cyc1 - cyc0, IDLE_CYCLES + 1);
    check_value("minstret delta", ret1 - ret0, retired);
  endtask

  initial begin
    nRST          = 1'b0;
    csr_valid     = 1'b0;
    csr_op        = CSR_RS;
    csr_addr      = 12'h000;
    csr_wdata     = 32'd0;
    instr_retired = 1'b0;
    exc_valid     = 1'b0;
    exc_cause     = EXC_ECALL_M;
    exc_pc        = 32'd0;
    exc_tval      = 32'd0;
    mret          = 1'b0;
    ext_irq       = 1'b0;
    build_table();
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    #1;
    check_value("trap_taken", trap_taken, 32'd0);
    check_value("csr_ready", csr_ready, 32'd1);
    for (int i = 0; i < steps.size(); i++) begin
      apply_step(steps[i]);
    end
    check_counters();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

/* priv_unit.sv */
// ------------------------------------------------------------
// Machine-mode privilege unit top level. Plain ports toward
// the pipeline, CSR file and trap control joined inside
// ------------------------------------------------------------
module priv_unit
  import rv32_csr_pkg::*;
  import rv32_trap_pkg::*;
#(
  parameter word_t HART_ID = 32'd0
) (
  input  logic       CLK,
  input  logic       nRST,
  // CSR request from the pipeline
  input  logic       csr_valid,
  output logic       csr_ready,
  input  csr_op_t    csr_op,
  input  csr_addr_t  csr_addr,
  input  word_t      csr_wdata,
  output word_t      csr_rdata,
  output logic       csr_illegal,
  // Pipeline status
  input  logic       instr_retired,
  input  logic       exc_valid,
  input  exc_cause_t exc_cause,
  input  word_t      exc_pc,
  input  word_t      exc_tval,
  input  logic       mret,
  input  logic       ext_irq,
  // Control flow change
  output logic       trap_taken,
  output word_t      redirect_pc
);

  priv_internal_if prv_if ();

  csr_rfile #(
    .HART_ID (HART_ID)
  ) csr_rfile_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .csr_valid     (csr_valid),
    .csr_ready     (csr_ready),
    .csr_op        (csr_op),
    .csr_addr      (csr_addr),
    .csr_wdata     (csr_wdata),
    .csr_rdata     (csr_rdata),
    .csr_illegal   (csr_illegal),
    .instr_retired (instr_retired),
    .ext_irq       (ext_irq),
    .prv           (prv_if.csr)
  );

  trap_ctrl trap_ctrl_i (
    .exc_valid   (exc_valid),
    .exc_cause   (exc_cause),
    .exc_pc      (exc_pc),
    .exc_tval    (exc_tval),
    .mret        (mret),
    .csr_ready   (csr_ready),
    .trap_taken  (trap_taken),
    .redirect_pc (redirect_pc),
    .prv         (prv_if.trap)
  );

endmodule

/* trap_ctrl.sv */
// ------------------------------------------------------------
// Combinational trap decision: interrupt masking, priority,
// mcause encoding, redirect pc and CSR port stall
// ------------------------------------------------------------
module trap_ctrl
  import rv32_csr_pkg::*;
  import rv32_trap_pkg::*;
(
  input  logic       exc_valid,
  input  exc_cause_t exc_cause,
  input  word_t      exc_pc,
  input  word_t      exc_tval,
  input  logic       mret,
  output logic       csr_ready,
  output logic       trap_taken,
  output word_t      redirect_pc,
  priv_internal_if.trap prv
);

  word_t      irq_pend;
  logic       irq_any;
  logic       irq_take;
  logic       mret_take;
  irq_cause_t irq_code;
  tvec_mode_t tvec_mode;
  word_t      tvec_base;
  word_t      cause;

  // Enabled pending set, gated globally by mstatus.MIE
  assign irq_pend = prv.mip & prv.mie;
  assign irq_any  = irq_pend[MIX_MEI] | irq_pend[MIX_MSI] | irq_pend[MIX_MTI];
  assign irq_take = prv.mstatus_mie & irq_any & ~exc_valid & ~mret;

  // External before software before timer
  always_comb begin
    if (irq_pend[MIX_MEI]) begin
      irq_code = IRQ_M_EXT;
    end else if (irq_pend[MIX_MSI]) begin
      irq_code = IRQ_M_SOFT;
    end else begin
      irq_code = IRQ_M_TIMER;
    end
  end

  // An exception in the same cycle wins over mret
  assign mret_take  = mret & ~exc_valid;
  assign trap_taken = exc_valid | irq_take;

  always_comb begin
    cause = '0;
    if (exc_valid) begin
      cause[CAUSE_W-1:0] = exc_cause;
    end else begin
      cause[INTR_BIT]    = 1'b1;
      cause[CAUSE_W-1:0] = irq_code;
    end
  end

  assign tvec_mode = tvec_mode_t'(prv.mtvec[1:0]);
  assign tvec_base = {prv.mtvec[31:2], 2'b00};

  always_comb begin
    if (mret_take) begin
      redirect_pc = prv.mepc;
    end else if (irq_take && (tvec_mode == TVEC_VECTORED)) begin
      redirect_pc = tvec_base + {26'd0, irq_code, 2'b00};
    end else begin
      redirect_pc = tvec_base;
    end
  end

  // Pipeline stalls its CSR request while a commit is in flight
  assign csr_ready = ~(trap_taken | mret_take);

  assign prv.trap_commit = trap_taken;
  assign prv.mret_commit = mret_take;
  assign prv.cause_next  = cause;
  // For interrupts the pipeline presents the resume pc on exc_pc
  assign prv.epc_next    = exc_pc;
  assign prv.tval_next   = exc_valid ? exc_tval : '0;

endmodule

/* csr_rfile.sv */
// ------------------------------------------------------------
// Machine CSR storage with timer and counters. Serves the
// pipeline CSR port and applies commits from the trap control
// ------------------------------------------------------------
module csr_rfile
  import rv32_csr_pkg::*;
#(
  parameter word_t HART_ID = 32'd0
) (
  input  logic      CLK,
  input  logic      nRST,
  input  logic      csr_valid,
  input  logic      csr_ready,
  input  csr_op_t   csr_op,
  input  csr_addr_t csr_addr,
  input  word_t     csr_wdata,
  output word_t     csr_rdata,
  output logic      csr_illegal,
  input  logic      instr_retired,
  input  logic      ext_irq,
  priv_internal_if.csr prv
);

  logic        mstatus_mie;
  logic        mstatus_mpie;
  word_t       mie;
  logic        msip;
  word_t       mtvec;
  word_t       mscratch;
  word_t       mepc;
  word_t       mcause;
  word_t       mtval;
  word_t       mtimecmp;
  logic [63:0] mtime;
  logic [63:0] mcycle;
  logic [63:0] minstret;

  word_t mstatus_w;
  word_t mip_w;
  logic  mtip;
  logic  addr_known;
  logic  read_only;
  logic  is_write;
  logic  wr_en;
  word_t csr_new;

  // Increment a 64-bit counter unless one of its halves is written
  function automatic logic [63:0] cnt_next(input logic [63:0] cur, input logic inc,
                                           input logic wr_lo, input logic wr_hi,
                                           input word_t data);
    logic [63:0] nxt;
    nxt = cur + {63'd0, inc};
    if (wr_lo) begin
      nxt = {cur[63:32], data};
    end
    if (wr_hi) begin
      nxt = {data, cur[31:0]};
    end
    return nxt;
  endfunction

  always_comb begin
    mstatus_w               = '0;
    mstatus_w[MSTATUS_MIE]  = mstatus_mie;
    mstatus_w[MSTATUS_MPIE] = mstatus_mpie;
  end

  assign mtip = mtime >= {32'd0, mtimecmp};

  always_comb begin
    mip_w          = '0;
    mip_w[MIX_MSI] = msip;
    mip_w[MIX_MTI] = mtip;
    mip_w[MIX_MEI] = ext_irq;
  end

  // Read mux and address decode showing the old value during the transfer
  always_comb begin
    addr_known = 1'b1;
    case (csr_addr)
      MVENDORID_ADDR: csr_rdata = MVENDORID_VALUE;
      MARCHID_ADDR:   csr_rdata = MARCHID_VALUE;
      MIMPID_ADDR:    csr_rdata = MIMPID_VALUE;
      MHARTID_ADDR:   csr_rdata = HART_ID;
      MISA_ADDR:      csr_rdata = MISA_VALUE;
      MSTATUS_ADDR:   csr_rdata = mstatus_w;
      MIE_ADDR:       csr_rdata = mie;
      MTVEC_ADDR:     csr_rdata = mtvec;
      MSCRATCH_ADDR:  csr_rdata = mscratch;
      MEPC_ADDR:      csr_rdata = mepc;
      MCAUSE_ADDR:    csr_rdata = mcause;
      MTVAL_ADDR:     csr_rdata = mtval;
      MIP_ADDR:       csr_rdata = mip_w;
      MTIMECMP_ADDR:  csr_rdata = mtimecmp;
      MTIME_ADDR:     csr_rdata = mtime[31:0];
      MTIMEH_ADDR:    csr_rdata = mtime[63:32];
      MCYCLE_ADDR:    csr_rdata = mcycle[31:0];
      MCYCLEH_ADDR:   csr_rdata = mcycle[63:32];
      MINSTRET_ADDR:  csr_rdata = minstret[31:0];
      MINSTRETH_ADDR: csr_rdata = minstret[63:32];
      default: begin
        addr_known = 1'b0;
        csr_rdata  = '0;
      end
    endcase
  end

  assign read_only = csr_addr inside {MISA_ADDR, MVENDORID_ADDR, MARCHID_ADDR,
                                      MIMPID_ADDR, MHARTID_ADDR};

  // Set or clear with a zero mask only reads as with rs1 = x0
  assign is_write    = (csr_op == CSR_RW) || (csr_wdata != '0);
  assign csr_illegal = ~addr_known | (read_only & is_write);
  assign wr_en       = csr_valid & csr_ready & is_write & ~csr_illegal;

  always_comb begin
    case (csr_op)
      CSR_RW:  csr_new = csr_wdata;
      CSR_RS:  csr_new = csr_rdata | csr_wdata;
      CSR_RC:  csr_new = csr_rdata & ~csr_wdata;
      default: csr_new = csr_rdata;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b0;
      mie          <= '0;
      msip         <= 1'b0;
      mtvec        <= '0;
      mscratch     <= '0;
      mepc         <= '0;
      mcause       <= '0;
      mtval        <= '0;
      mtimecmp     <= '0;
      mtime        <= '0;
      mcycle       <= '0;
      minstret     <= '0;
    end else begin
      mtime    <= cnt_next(mtime, 1'b1, wr_en && (csr_addr == MTIME_ADDR),
                           wr_en && (csr_addr == MTIMEH_ADDR), csr_new);
      mcycle   <= cnt_next(mcycle, 1'b1, wr_en && (csr_addr == MCYCLE_ADDR),
                           wr_en && (csr_addr == MCYCLEH_ADDR), csr_new);
      minstret <= cnt_next(minstret, instr_retired, wr_en && (csr_addr == MINSTRET_ADDR),
                           wr_en && (csr_addr == MINSTRETH_ADDR), csr_new);

      // Trap and mret updates take precedence over the pipeline
      if (prv.trap_commit) begin
        mepc         <= prv.epc_next;
        mcause       <= prv.cause_next;
        mtval        <= prv.tval_next;
        mstatus_mpie <= mstatus_mie;
        mstatus_mie  <= 1'b0;
      end else if (prv.mret_commit) begin
        mstatus_mie  <= mstatus_mpie;
        mstatus_mpie <= 1'b1;
      end else if (wr_en) begin
        case (csr_addr)
          MSTATUS_ADDR: begin
            mstatus_mie  <= csr_new[MSTATUS_MIE];
            mstatus_mpie <= csr_new[MSTATUS_MPIE];
          end
          MIE_ADDR:      mie      <= csr_new & MIX_MASK;
          MIP_ADDR:      msip     <= csr_new[MIX_MSI];
          MTVEC_ADDR:    mtvec    <= csr_new;
          MSCRATCH_ADDR: mscratch <= csr_new;
          MEPC_ADDR:     mepc     <= csr_new;
          MCAUSE_ADDR:   mcause   <= csr_new;
          MTVAL_ADDR:    mtval    <= csr_new;
          MTIMECMP_ADDR: mtimecmp <= csr_new;
          default: ;
        endcase
      end
    end
  end

  assign prv.mtvec       = mtvec;
  assign prv.mepc        = mepc;
  assign prv.mstatus_mie = mstatus_mie;
  assign prv.mie         = mie;
  assign prv.mip         = mip_w;

endmodule

/* priv_internal_if.sv */
// ------------------------------------------------------------
// Link between the CSR register file and the trap controller.
// The csr side exports trap state, the trap side commits traps
// ------------------------------------------------------------
interface priv_internal_if
  import rv32_csr_pkg::*;
();

  // Trap decisions, valid in the cycle they are raised
  logic  trap_commit;
  logic  mret_commit;
  word_t cause_next;
  word_t epc_next;
  word_t tval_next;

  // Current CSR state seen by the trap logic
  word_t mtvec;
  word_t mepc;
  logic  mstatus_mie;
  word_t mie;
  word_t mip;

  modport csr (
    input  trap_commit,
    input  mret_commit,
    input  cause_next,
    input  epc_next,
    input  tval_next,
    output mtvec,
    output mepc,
    output mstatus_mie,
    output mie,
    output mip
  );

  modport trap (
    output trap_commit,
    output mret_commit,
    output cause_next,
    output epc_next,
    output tval_next,
    input  mtvec,
    input  mepc,
    input  mstatus_mie,
    input  mie,
    input  mip
  );

endinterface

/* rv32_trap_pkg.sv */
// ------------------------------------------------------------
// Trap encodings: exception and interrupt cause codes, the
// mcause interrupt flag and the mtvec mode field
// ------------------------------------------------------------
package rv32_trap_pkg;

  localparam int CAUSE_W  = 4;
  localparam int INTR_BIT = 31;

  // Synchronous exceptions reported by the pipeline
  typedef enum logic [CAUSE_W-1:0] {
    EXC_INSTR_MISALIGN = 4'd0,
    EXC_ILLEGAL_INSTR  = 4'd2,
    EXC_BREAKPOINT     = 4'd3,
    EXC_LOAD_FAULT     = 4'd5,
    EXC_STORE_FAULT    = 4'd7,
    EXC_ECALL_M        = 4'd11
  } exc_cause_t;

  // Machine interrupts, code equals the mie/mip bit index
  typedef enum logic [CAUSE_W-1:0] {
    IRQ_M_SOFT  = 4'd3,
    IRQ_M_TIMER = 4'd7,
    IRQ_M_EXT   = 4'd11
  } irq_cause_t;

  // mtvec[1:0], reserved modes behave as direct
  typedef enum logic [1:0] {
    TVEC_DIRECT   = 2'b00,
    TVEC_VECTORED = 2'b01
  } tvec_mode_t;

endpackage

/* rv32_csr_pkg.sv */
// ------------------------------------------------------------
// Machine CSR map of the RV32 privilege unit: addresses, CSR
// opcodes, mstatus and mie/mip bit positions, ISA constants
// ------------------------------------------------------------
package rv32_csr_pkg;

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] word_t;

  // Same encoding as funct3[1:0] of the Zicsr instructions
  typedef enum logic [1:0] {
    CSR_RW = 2'b01,
    CSR_RS = 2'b10,
    CSR_RC = 2'b11
  } csr_op_t;

  // Machine information registers
  localparam csr_addr_t MVENDORID_ADDR = 12'hF11;
  localparam csr_addr_t MARCHID_ADDR   = 12'hF12;
  localparam csr_addr_t MIMPID_ADDR    = 12'hF13;
  localparam csr_addr_t MHARTID_ADDR   = 12'hF14;

  // Trap setup and handling
  localparam csr_addr_t MSTATUS_ADDR   = 12'h300;
  localparam csr_addr_t MISA_ADDR      = 12'h301;
  localparam csr_addr_t MIE_ADDR       = 12'h304;
  localparam csr_addr_t MTVEC_ADDR     = 12'h305;
  localparam csr_addr_t MSCRATCH_ADDR  = 12'h340;
  localparam csr_addr_t MEPC_ADDR      = 12'h341;
  localparam csr_addr_t MCAUSE_ADDR    = 12'h342;
  localparam csr_addr_t MTVAL_ADDR     = 12'h343;
  localparam csr_addr_t MIP_ADDR       = 12'h344;

  // Timer, kept in the CSR space of this core
  localparam csr_addr_t MTIMECMP_ADDR  = 12'h321;
  localparam csr_addr_t MTIME_ADDR     = 12'h701;
  localparam csr_addr_t MTIMEH_ADDR    = 12'h741;

  // 64-bit counters
  localparam csr_addr_t MCYCLE_ADDR    = 12'hB00;
  localparam csr_addr_t MINSTRET_ADDR  = 12'hB02;
  localparam csr_addr_t MCYCLEH_ADDR   = 12'hB80;
  localparam csr_addr_t MINSTRETH_ADDR = 12'hB82;

  // mstatus fields held by this machine-only core
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

  // Bit positions shared by mie and mip
  localparam int MIX_MSI = 3;
  localparam int MIX_MTI = 7;
  localparam int MIX_MEI = 11;
  localparam word_t MIX_MASK = (32'd1 << MIX_MSI) | (32'd1 << MIX_MTI) | (32'd1 << MIX_MEI);

  // ISA and identification
  localparam logic [1:0] MISA_MXL_32 = 2'b01;
  localparam logic [25:0] MISA_EXT_I = 26'd1 << 8;
  localparam word_t MISA_VALUE = {MISA_MXL_32, 4'b0000, MISA_EXT_I};
  localparam word_t MVENDORID_VALUE = 32'd0;
  localparam word_t MARCHID_VALUE   = 32'd0;
  localparam word_t MIMPID_VALUE    = 32'd0;

endpackage
